/* list.f */
hdl/id_pkg.sv
hdl/id_ifs.sv
hdl/instr_decoder.sv
hdl/operand_mux.sv
hdl/id_ex_pipe.sv
hdl/id_stage_top.sv
tb/id_stage_sva.sv
tb/tb_id_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Run and fail unless the pass line is printed
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_id_stage.sv */
//////////////////////////////
// Random test of the decode stage against a reference model
// One item in flight, so the queue holds at most one record
// Watchdog allows four cycles per instruction
//////////////////////////////
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int N_INSTR         = 2000;
  localparam int SEED            = 79;
  localparam int STALL_PCT       = 25;
  localparam int VALID_PCT       = 80;
  localparam int WATCHDOG_CYCLES = 4 * N_INSTR;

  // Expected ID/EX record
  typedef struct packed {
    alu_op_e   alu_op;
    word_t     a;
    word_t     b;
    word_t     c;
    logic      rf_we;
    reg_addr_t waddr;
    logic      branch;
    logic      illegal;
    word_t     pc;
  } exp_t;

  logic      clk = 1'b0;
  logic      rst_n = 1'b1;
  logic      in_valid_i;
  logic      in_ready_o;
  word_t     instr_i;
  word_t     pc_i;
  word_t     rs1_rdata_i;
  word_t     rs2_rdata_i;
  logic      out_valid_o;
  logic      out_ready_i;
  alu_op_e   alu_op_o;
  word_t     operand_a_o;
  word_t     operand_b_o;
  word_t     operand_c_o;
  logic      rf_we_o;
  reg_addr_t rf_waddr_o;
  logic      branch_o;
  logic      illegal_o;
  word_t     pc_o;

  exp_t  exp_q[$];
  string name_q[$];
  // Input transfer seen on the last rising edge
  bit    in_acc = 1'b0;
  int    n_acc = 0;
  int    err_cnt = 0;
  int    check_cnt = 0;

  always #2 clk = ~clk;

  id_stage_top dut_i (.*);

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_op(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_EQ;
      3'd1:    return ALU_NE;
      3'd4:    return ALU_LT;
      3'd5:    return ALU_GE;
      3'd6:    return ALU_LTU;
      default: return ALU_GEU;
    endcase
  endfunction

  function automatic exp_t ref_decode(input word_t ins, input word_t pc, input word_t rs1,
                                      input word_t rs2);
    exp_t       e;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    logic       ok;
    f3    = ins[14:12];
    f7    = ins[31:25];
    // Immediate formats straight from the ISA tables
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'h000};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    e         = '0;
    e.alu_op  = ALU_ADD;
    e.a       = rs1;
    e.b       = rs2;
    e.c       = rs2;
    e.waddr   = ins[11:7];
    e.pc      = pc;
    e.rf_we   = 1'b1;
    ok        = 1'b1;
    case (ins[6:0])
      OPC_LUI: begin
        e.a = '0;
        e.b = imm_u;
      end
      OPC_AUIPC: begin
        e.a = pc;
        e.b = imm_u;
      end
      OPC_JAL: begin
        e.a = pc;
        e.b = 32'd4;
        e.c = pc + imm_j;
      end
      OPC_JALR: begin
        ok  = (f3 == 3'd0);
        e.a = pc;
        e.b = 32'd4;
        e.c = (rs1 + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        ok       = (f3 != 3'd2) && (f3 != 3'd3);
        e.alu_op = branch_op(f3);
        e.c      = pc + imm_b;
        e.branch = 1'b1;
        e.rf_we  = 1'b0;
      end
      OPC_OP_IMM: begin
        // Only SRAI uses bit 30 as an opcode bit
        e.b      = imm_i;
        e.alu_op = arith_op(f3, (f3 == 3'd5) && f7[5]);
        if (f3 == 3'd1) begin
          ok = (f7 == 7'h00);
        end else if (f3 == 3'd5) begin
          ok = (f7 == 7'h00) || (f7 == 7'h20);
        end
      end
      OPC_OP: begin
        e.alu_op = arith_op(f3, f7[5]);
        ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
      end
      default: ok = 1'b0;
    endcase
    // Rejected words carry the idle shape
    if (!ok) begin
      e.alu_op  = ALU_ADD;
      e.a       = rs1;
      e.b       = rs2;
      e.c       = rs2;
      e.rf_we   = 1'b0;
      e.branch  = 1'b0;
      e.illegal = 1'b1;
    end
    return e;
  endfunction

  function automatic string class_of(input word_t ins, input logic ill);
    if (ill) begin
      return "illegal";
    end
    case (ins[6:0])
      OPC_LUI:    return "lui";
      OPC_AUIPC:  return "auipc";
      OPC_JAL:    return "jal";
      OPC_JALR:   return "jalr";
      OPC_BRANCH: return "branch";
      OPC_OP_IMM: return "op_imm";
      default:    return "op";
    endcase
  endfunction

  // Mostly kept opcodes, some raw random words
  function automatic word_t pick_instr();
    word_t w;
    int    kind;
    w    = $urandom();
    kind = $urandom_range(0, 9);
    case (kind)
      0: w[6:0] = OPC_LUI;
      1: w[6:0] = OPC_AUIPC;
      2: w[6:0] = OPC_JAL;
      3: begin
        w[6:0] = OPC_JALR;
        if ($urandom_range(0, 7) != 0) begin
          w[14:12] = 3'd0;
        end
      end
      4: w[6:0] = OPC_BRANCH;
      5, 6: begin
        w[6:0] = OPC_OP_IMM;
        if (w[13:12] == 2'b01 && $urandom_range(0, 7) != 0) begin
          // Shift encodings, bit 30 picks SRAI
          w[31]    = 1'b0;
          w[29:25] = 5'd0;
          w[30]    = w[30] & w[14];
        end
      end
      7, 8: begin
        w[6:0] = OPC_OP;
        if ($urandom_range(0, 7) != 0) begin
          w[31]    = 1'b0;
          w[29:25] = 5'd0;
        end
      end
      default: ;
    endcase
    return w;
  endfunction

  task automatic check_field(input string test, input string field, input word_t exp,
                             input word_t act);
    check_cnt++;
    assert (act === exp) else begin
      err_cnt++;
      $display("CHECK FAILED %s %s expected %h actual %h", test, field, exp, act);
    end
  endtask

  task automatic end_run(input bit timed_out);
    $display("Checks %0d, errors %0d, accepted %0d of %0d", check_cnt, err_cnt, n_acc, N_INSTR);
    if (err_cnt == 0 && !timed_out && n_acc == N_INSTR) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  //////////////////////////////
  // Scoreboard
  //////////////////////////////
  always @(posedge clk) begin : scoreboard
    exp_t  e;
    string nm;
    if (!rst_n) begin
      check_field("reset", "out_valid", '0, 32'(out_valid_o));
      check_field("reset", "in_ready", 32'd1, 32'(in_ready_o));
      check_field("reset", "flags", '0, 32'({rf_we_o, branch_o, illegal_o}));
      check_field("reset", "alu_op", 32'(ALU_ADD), 32'(alu_op_o));
      check_field("reset", "operand_a", '0, operand_a_o);
      check_field("reset", "operand_b", '0, operand_b_o);
      check_field("reset", "operand_c", '0, operand_c_o);
      check_field("reset", "rf_waddr", '0, 32'(rf_waddr_o));
      check_field("reset", "pc", '0, pc_o);
    end else begin
      // Accepted on the last edge, so it must be presented now
      if (in_acc) begin
        assert (out_valid_o && exp_q.size() == 1) else begin
          err_cnt++;
          $display("ERROR: instruction %0d not presented one cycle after acceptance", n_acc - 1);
        end
      end
      if (out_valid_o && out_ready_i) begin
        // A leaving record frees the register for the next word
        check_field("handshake", "in_ready", 32'd1, 32'(in_ready_o));
        assert (exp_q.size() != 0) else begin
          err_cnt++;
          $display("ERROR: output transfer with no accepted instruction pending");
        end
        if (exp_q.size() != 0) begin
          e  = exp_q.pop_front();
          nm = name_q.pop_front();
          check_field(nm, "alu_op", 32'(e.alu_op), 32'(alu_op_o));
          check_field(nm, "operand_a", e.a, operand_a_o);
          check_field(nm, "operand_b", e.b, operand_b_o);
          check_field(nm, "operand_c", e.c, operand_c_o);
          check_field(nm, "rf_we", 32'(e.rf_we), 32'(rf_we_o));
          check_field(nm, "rf_waddr", 32'(e.waddr), 32'(rf_waddr_o));
          check_field(nm, "branch", 32'(e.branch), 32'(branch_o));
          check_field(nm, "illegal", 32'(e.illegal), 32'(illegal_o));
          check_field(nm, "pc", e.pc, pc_o);
        end
      end
      in_acc = in_valid_i && in_ready_o;
      if (in_acc) begin
        e = ref_decode(instr_i, pc_i, rs1_rdata_i, rs2_rdata_i);
        exp_q.push_back(e);
        name_q.push_back($sformatf("%s#%0d", class_of(instr_i, e.illegal), n_acc));
        n_acc++;
      end
    end
  end

  //////////////////////////////
  // Stimulus, driven on falling edges
  //////////////////////////////
  initial begin : stimulus
    int issued;
    bit busy;
    issued      = 0;
    busy        = 1'b1;
    void'($urandom(SEED));
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    instr_i     = '0;
    pc_i        = '0;
    rs1_rdata_i = '0;
    rs2_rdata_i = '0;
    #1 rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (busy) begin
      @(negedge clk);
      out_ready_i = ($urandom_range(0, 99) >= STALL_PCT);
      // Hold the word until it is taken
      if (!in_valid_i || in_acc) begin
        in_valid_i = 1'b0;
        if (issued == N_INSTR) begin
          busy = 1'b0;
        end else if ($urandom_range(0, 99) < VALID_PCT) begin
          instr_i     = pick_instr();
          pc_i        = $urandom() & 32'hFFFF_FFFC;
          rs1_rdata_i = $urandom();
          rs2_rdata_i = $urandom();
          in_valid_i  = 1'b1;
          issued++;
        end
      end
    end
    // Drain the last record
    out_ready_i = 1'b1;
    while (out_valid_o || exp_q.size() != 0) begin
      @(negedge clk);
    end
    end_run(1'b0);
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    end_run(1'b1);
  end

endmodule

/* tb/id_stage_sva.sv */
//////////////////////////////
// Handshake checks on the ID/EX register
// Bound into every id_ex_pipe instance
//////////////////////////////
`timescale 1ns/1ps

module id_stage_sva import id_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      in_ready_o,
  input logic      out_valid_o,
  input logic      out_ready_i,
  input logic      rf_we_o,
  input logic      branch_o,
  input logic      illegal_o,
  input alu_op_e   alu_op_o,
  input word_t     operand_a_o,
  input word_t     operand_b_o,
  input word_t     operand_c_o,
  input reg_addr_t rf_waddr_o,
  input word_t     pc_o
);

  // Stalled record stays frozen
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable({alu_op_o, operand_a_o,
      operand_b_o, operand_c_o, rf_we_o, rf_waddr_o, branch_o, illegal_o, pc_o}))
    else $error("ID/EX record changed under back-pressure");

  // Empty register always accepts
  ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid_o |-> in_ready_o)
    else $error("in_ready_o low with an empty ID/EX register");

  no_flags_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !out_valid_o |-> !(rf_we_o || branch_o || illegal_o))
    else $error("flag raised while out_valid_o is low");

endmodule

bind id_ex_pipe id_stage_sva sva_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .rf_we_o     (rf_we_o),
  .branch_o    (branch_o),
  .illegal_o   (illegal_o),
  .alu_op_o    (alu_op_o),
  .operand_a_o (operand_a_o),
  .operand_b_o (operand_b_o),
  .operand_c_o (operand_c_o),
  .rf_waddr_o  (rf_waddr_o),
  .pc_o        (pc_o)
);

/* hdl/id_stage_top.sv */
//////////////////////////////
// Decode stage top, plain ports only
// Sender holds inputs stable until in_ready_o accepts them
//////////////////////////////
`timescale 1ns/1ps

module id_stage_top import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Input side
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  word_t     instr_i,
  input  word_t     pc_i,
  input  word_t     rs1_rdata_i,
  input  word_t     rs2_rdata_i,
  // Output side, ID/EX record
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output alu_op_e   alu_op_o,
  output word_t     operand_a_o,
  output word_t     operand_b_o,
  output word_t     operand_c_o,
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output logic      branch_o,
  output logic      illegal_o,
  output word_t     pc_o
);

  decode_if dec_if ();
  issue_if  iss_if ();

  // Combinational decode
  instr_decoder decoder_i (
    .instr_i (instr_i),
    .dec     (dec_if.driver)
  );

  operand_mux opmux_i (
    .instr_i     (instr_i),
    .pc_i        (pc_i),
    .rs1_rdata_i (rs1_rdata_i),
    .rs2_rdata_i (rs2_rdata_i),
    .dec         (dec_if.receiver),
    .iss         (iss_if.driver)
  );

  // The only sequential stage
  id_ex_pipe pipe_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .out_ready_i (out_ready_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .iss         (iss_if.receiver),
    .alu_op_o    (alu_op_o),
    .operand_a_o (operand_a_o),
    .operand_b_o (operand_b_o),
    .operand_c_o (operand_c_o),
    .pc_o        (pc_o),
    .rf_we_o     (rf_we_o),
    .branch_o    (branch_o),
    .illegal_o   (illegal_o),
    .rf_waddr_o  (rf_waddr_o)
  );

endmodule

/* hdl/id_ex_pipe.sv */
//////////////////////////////
// Single entry ID/EX register, valid/ready on both sides
// One cycle latency, full throughput when out_ready_i is high
// in_ready_o depends combinationally on out_ready_i
//////////////////////////////
`timescale 1ns/1ps

module id_ex_pipe import id_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid_i,
  input  logic       out_ready_i,
  output logic       in_ready_o,
  output logic       out_valid_o,
  issue_if.receiver  iss,
  output alu_op_e    alu_op_o,
  output word_t      operand_a_o,
  output word_t      operand_b_o,
  output word_t      operand_c_o,
  output word_t      pc_o,
  output logic       rf_we_o,
  output logic       branch_o,
  output logic       illegal_o,
  output reg_addr_t  rf_waddr_o
);

  logic in_xfer;

  // Accept when empty or when the current record leaves this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign in_xfer    = in_valid_i && in_ready_o;

  //////////////////////////////
  // Valid and flags
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
      rf_we_o     <= 1'b0;
      branch_o    <= 1'b0;
      illegal_o   <= 1'b0;
    end else if (in_xfer) begin
      out_valid_o <= 1'b1;
      rf_we_o     <= iss.rf_we;
      branch_o    <= iss.branch;
      illegal_o   <= iss.illegal;
    end else if (out_ready_i) begin
      // Drained with nothing behind it, flags drop with valid
      out_valid_o <= 1'b0;
      rf_we_o     <= 1'b0;
      branch_o    <= 1'b0;
      illegal_o   <= 1'b0;
    end
  end

  // Payload, loaded only on an input transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_op_o    <= ALU_ADD;
      operand_a_o <= '0;
      operand_b_o <= '0;
      operand_c_o <= '0;
      rf_waddr_o  <= '0;
      pc_o        <= '0;
    end else if (in_xfer) begin
      alu_op_o    <= iss.alu_op;
      operand_a_o <= iss.operand_a;
      operand_b_o <= iss.operand_b;
      operand_c_o <= iss.operand_c;
      rf_waddr_o  <= iss.rf_waddr;
      pc_o        <= iss.pc;
    end
  end

endmodule

/* hdl/operand_mux.sv */
//////////////////////////////
// Immediates, operand selection and transfer targets
// Read values arrive already resolved, no forwarding here
//////////////////////////////
`timescale 1ns/1ps

module operand_mux import id_pkg::*; (
  input  word_t      instr_i,
  input  word_t      pc_i,
  input  word_t      rs1_rdata_i,
  input  word_t      rs2_rdata_i,
  decode_if.receiver dec,
  issue_if.driver    iss
);

  word_t imm_i;
  word_t imm_u;
  word_t imm_b;
  word_t imm_j;
  word_t imm;
  word_t bch_target;
  word_t jalr_sum;
  word_t jmp_target;
  word_t operand_a;
  word_t operand_b;
  word_t operand_c;

  //////////////////////////////
  // Immediate extraction
  //////////////////////////////
  // I type is funct7 and rs2 fields together
  assign imm_i = {{20{instr_i[XLEN-1]}}, instr_i[F7_MSB:F7_LSB], instr_i[RS2_MSB:RS2_LSB]};
  assign imm_u = {instr_i[31:12], 12'b0};
  // B type, bit 11 sits in the rd LSB position
  assign imm_b = {{19{instr_i[XLEN-1]}}, instr_i[31], instr_i[RD_LSB],
                  instr_i[30:25], instr_i[11:8], 1'b0};
  // J type reuses the rs1 and funct3 fields for bits 19:12
  assign imm_j = {{11{instr_i[XLEN-1]}}, instr_i[31], instr_i[RS1_MSB:RS1_LSB],
                  instr_i[F3_MSB:F3_LSB], instr_i[RS2_LSB], instr_i[30:21], 1'b0};

  always_comb begin
    case (dec.imm_sel)
      IMM_U:   imm = imm_u;
      IMM_B:   imm = imm_b;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  //////////////////////////////
  // Control transfer targets
  //////////////////////////////
  // Selected immediate is B for branches, J for JAL and I for JALR
  assign bch_target = pc_i + imm;
  assign jalr_sum   = rs1_rdata_i + imm;
  // JAL is PC relative, JALR clears bit 0 of rs1 + imm
  assign jmp_target = (dec.imm_sel == IMM_J) ? (pc_i + imm) :
                      {jalr_sum[XLEN-1:1], 1'b0};

  // Operand A
  always_comb begin
    case (dec.op_a_sel)
      OP_A_PC:   operand_a = pc_i;
      OP_A_ZERO: operand_a = '0;
      default:   operand_a = rs1_rdata_i;
    endcase
  end

  // Operand B
  always_comb begin
    case (dec.op_b_sel)
      OP_B_IMM:    operand_b = imm;
      OP_B_PCINCR: operand_b = word_t'(PC_INCR);
      default:     operand_b = rs2_rdata_i;
    endcase
  end

  // Operand C
  always_comb begin
    case (dec.op_c_sel)
      OP_C_BCH: operand_c = bch_target;
      OP_C_JMP: operand_c = jmp_target;
      default:  operand_c = rs2_rdata_i;
    endcase
  end

  // Issue record
  assign iss.alu_op    = dec.alu_op;
  assign iss.operand_a = operand_a;
  assign iss.operand_b = operand_b;
  assign iss.operand_c = operand_c;
  assign iss.rf_we     = dec.rf_we;
  assign iss.rf_waddr  = instr_i[RD_MSB:RD_LSB];
  assign iss.branch    = dec.branch;
  assign iss.illegal   = dec.illegal;
  assign iss.pc        = pc_i;

endmodule

/* hdl/instr_decoder.sv */
//////////////////////////////
// Combinational RV32I subset decoder
// Anything outside the kept opcodes is flagged illegal
// Illegal words leave default selects and no side effects
//////////////////////////////
`timescale 1ns/1ps

module instr_decoder import id_pkg::*; (
  input  word_t    instr_i,
  decode_if.driver dec
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_b5;
  logic       f7_zero;
  logic       f7_alt;

  alu_op_e    alu_op;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_sel_e   imm_sel;
  op_c_sel_e  op_c_sel;
  logic       rf_we;
  logic       branch;
  logic       illegal;

  // Field extraction
  assign opcode  = opcode_e'(instr_i[OPC_MSB:OPC_LSB]);
  assign funct3  = instr_i[F3_MSB:F3_LSB];
  assign funct7  = instr_i[F7_MSB:F7_LSB];
  assign f7_b5   = instr_i[FUNCT7_B5];
  // Only two funct7 patterns exist in the base set
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  //////////////////////////////
  // Main decode
  //////////////////////////////
  always_comb begin
    // Defaults: register-register shape, nothing written
    alu_op   = ALU_ADD;
    op_a_sel = OP_A_RS1;
    op_b_sel = OP_B_RS2;
    imm_sel  = IMM_I;
    op_c_sel = OP_C_RS2;
    rf_we    = 1'b0;
    branch   = 1'b0;
    illegal  = 1'b0;

    case (opcode)
      OPC_LUI: begin
        // rd = 0 + U immediate
        op_a_sel = OP_A_ZERO;
        op_b_sel = OP_B_IMM;
        imm_sel  = IMM_U;
        rf_we    = 1'b1;
      end
      OPC_AUIPC: begin
        op_a_sel = OP_A_PC;
        op_b_sel = OP_B_IMM;
        imm_sel  = IMM_U;
        rf_we    = 1'b1;
      end
      OPC_JAL: begin
        // Link value PC + 4 goes through the ALU
        op_a_sel = OP_A_PC;
        op_b_sel = OP_B_PCINCR;
        imm_sel  = IMM_J;
        op_c_sel = OP_C_JMP;
        rf_we    = 1'b1;
      end
      OPC_JALR: begin
        op_a_sel = OP_A_PC;
        op_b_sel = OP_B_PCINCR;
        imm_sel  = IMM_I;
        op_c_sel = OP_C_JMP;
        rf_we    = 1'b1;
        illegal  = (funct3 != 3'd0);
      end
      OPC_BRANCH: begin
        // Compare rs1 against rs2, target travels in operand C
        imm_sel  = IMM_B;
        op_c_sel = OP_C_BCH;
        branch   = 1'b1;
        case (funct3)
          3'd0:    alu_op = ALU_EQ;
          3'd1:    alu_op = ALU_NE;
          3'd4:    alu_op = ALU_LT;
          3'd5:    alu_op = ALU_GE;
          3'd6:    alu_op = ALU_LTU;
          3'd7:    alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        op_b_sel = OP_B_IMM;
        imm_sel  = IMM_I;
        rf_we    = 1'b1;
        case (funct3)
          3'd0: alu_op = ALU_ADD;
          3'd1: begin
            alu_op  = ALU_SLL;
            illegal = !f7_zero;
          end
          3'd2: alu_op = ALU_SLT;
          3'd3: alu_op = ALU_SLTU;
          3'd4: alu_op = ALU_XOR;
          3'd5: begin
            // SRAI carries the alternate funct7
            alu_op  = f7_b5 ? ALU_SRA : ALU_SRL;
            illegal = !(f7_zero || f7_alt);
          end
          3'd6: alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPC_OP: begin
        rf_we   = 1'b1;
        // Alternate funct7 only for SUB and SRA
        illegal = !(f7_zero || (f7_alt && (funct3 == 3'd0 || funct3 == 3'd5)));
        case (funct3)
          3'd0:    alu_op = f7_b5 ? ALU_SUB : ALU_ADD;
          3'd1:    alu_op = ALU_SLL;
          3'd2:    alu_op = ALU_SLT;
          3'd3:    alu_op = ALU_SLTU;
          3'd4:    alu_op = ALU_XOR;
          3'd5:    alu_op = f7_b5 ? ALU_SRA : ALU_SRL;
          3'd6:    alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // Illegal words fall back to the idle shape
    if (illegal) begin
      alu_op   = ALU_ADD;
      op_a_sel = OP_A_RS1;
      op_b_sel = OP_B_RS2;
      imm_sel  = IMM_I;
      op_c_sel = OP_C_RS2;
      rf_we    = 1'b0;
      branch   = 1'b0;
    end
  end

  assign dec.alu_op   = alu_op;
  assign dec.op_a_sel = op_a_sel;
  assign dec.op_b_sel = op_b_sel;
  assign dec.imm_sel  = imm_sel;
  assign dec.op_c_sel = op_c_sel;
  assign dec.rf_we    = rf_we;
  assign dec.branch   = branch;
  assign dec.illegal  = illegal;

endmodule

/* hdl/id_ifs.sv */
//////////////////////////////
// Internal bundles of the decode stage
// Both are purely combinational, no handshake inside
//////////////////////////////
`timescale 1ns/1ps

// Decoder controls toward the operand mux
interface decode_if import id_pkg::*; ();
  alu_op_e   alu_op;
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  imm_sel_e  imm_sel;
  op_c_sel_e op_c_sel;
  logic      rf_we;
  logic      branch;
  logic      illegal;

  modport driver (
    output alu_op, op_a_sel, op_b_sel, imm_sel, op_c_sel, rf_we, branch, illegal
  );
  modport receiver (
    input alu_op, op_a_sel, op_b_sel, imm_sel, op_c_sel, rf_we, branch, illegal
  );
endinterface

// Complete ID/EX record before the pipe register
interface issue_if import id_pkg::*; ();
  alu_op_e   alu_op;
  word_t     operand_a;
  word_t     operand_b;
  // rs2 value or control transfer target
  word_t     operand_c;
  logic      rf_we;
  reg_addr_t rf_waddr;
  logic      branch;
  logic      illegal;
  word_t     pc;

  modport driver (
    output alu_op, operand_a, operand_b, operand_c, rf_we, rf_waddr, branch, illegal, pc
  );
  modport receiver (
    input alu_op, operand_a, operand_b, operand_c, rf_we, rf_waddr, branch, illegal, pc
  );
endinterface

/* hdl/id_pkg.sv */
//////////////////////////////
// Shared widths, field positions and decode enums
// RV32I subset: LUI, AUIPC, JAL, JALR, BRANCH, OP-IMM, OP
// Compressed encodings are not recognized
//////////////////////////////
package id_pkg;

  // Data path and register file widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Instruction field positions
  //////////////////////////////
  localparam int OPC_MSB   = 6;
  localparam int OPC_LSB   = 0;
  localparam int RD_MSB    = 11;
  localparam int RD_LSB    = 7;
  localparam int F3_MSB    = 14;
  localparam int F3_LSB    = 12;
  localparam int RS1_MSB   = 19;
  localparam int RS1_LSB   = 15;
  localparam int RS2_MSB   = 24;
  localparam int RS2_LSB   = 20;
  localparam int F7_MSB    = 31;
  localparam int F7_LSB    = 25;
  // Selects SUB over ADD and SRA over SRL
  localparam int FUNCT7_B5 = 30;

  // Link increment, no compressed support so always a full word
  localparam int PC_INCR = 4;

  // Major opcodes that the stage accepts
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // ALU operations, ADD is the reset and idle value
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    // Branch compares
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_RS1, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_RS2, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_U, IMM_B, IMM_J} imm_sel_e;
  typedef enum logic [1:0] {OP_C_RS2, OP_C_BCH, OP_C_JMP} op_c_sel_e;

endpackage
